//--- rtl/scope_rate_pkg.sv
package scope_rate_pkg;

  // ============================================================
  // Widths and types
  // ============================================================

  // Sample divider count
  typedef logic [15:0] count_t;

  // Signed offset added to the default count
  typedef logic signed [15:0] speed_t;

  // Active-low segments, bit 0 is segment a
  typedef logic [6:0] seg_t;

  typedef logic [3:0] nibble_t;

  typedef struct packed {
    seg_t digit5;
    seg_t digit4;
    seg_t digit3;
    seg_t digit2;
    seg_t digit1;
    seg_t digit0;
  } hex_bus_t;

  // up and down are one-cycle pulses, hold_zero is a level
  typedef struct packed {
    logic up;
    logic down;
    logic hold_zero;
  } speed_events_t;

  // ============================================================
  // Top-level parameter defaults
  // ============================================================

  // 1 kHz tick from 50 MHz
  parameter int unsigned DEF_TICK_CYCLES = 50000;
  // 10 repeats per second
  parameter int unsigned DEF_REPEAT_TICKS = 100;
  // Display refresh at 2 Hz
  parameter int unsigned DEF_REFRESH_CYCLES = 25000000;
  parameter count_t DEF_DEFAULT_COUNT = 16'd12499;
  parameter speed_t DEF_SPEED_STEP = 16'sd100;

endpackage

//--- rtl/key_repeat_gate.sv
`timescale 1ns/1ns

module key_repeat_gate #(
  parameter int unsigned tick_cycles  = 4,
  parameter int unsigned repeat_ticks = 4
) (
  input  logic                          CLK_50M,
  input  logic                          rst,
  input  logic [2:0]                    key,
  output scope_rate_pkg::speed_events_t events
);

  localparam int tick_w = (tick_cycles > 1) ? $clog2(tick_cycles) : 1;
  localparam int rep_w  = (repeat_ticks > 1) ? $clog2(repeat_ticks) : 1;

  logic [2:0]        key_meta;
  logic [2:0]        key_sync;
  logic [tick_w-1:0] tick_cnt;
  logic [rep_w-1:0]  rep_cnt;
  logic              tick;
  logic              rep_wrap;

  // Keys are active low, invert before the two sync flops
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      key_meta <= '0;
      key_sync <= '0;
    end
    else
    begin
      key_meta <= ~key;
      key_sync <= key_meta;
    end
  end

  // ============================================================
  // Slow tick and repeat counter
  // ============================================================

  assign tick     = (tick_cnt == tick_w'(tick_cycles - 1));
  assign rep_wrap = tick && (rep_cnt == rep_w'(repeat_ticks - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      tick_cnt <= '0;
      rep_cnt  <= '0;
    end
    else
    begin
      tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
      if (tick)
        rep_cnt <= rep_wrap ? '0 : rep_cnt + 1'b1;
    end
  end

  // Both directions may fire on the same wrap
  always_comb
  begin
    events.up        = rep_wrap && key_sync[0];
    events.down      = rep_wrap && key_sync[1];
    events.hold_zero = key_sync[2];
  end

endmodule

//--- rtl/speed_config.sv
`timescale 1ns/1ns

module speed_config #(
  parameter scope_rate_pkg::count_t default_count = 16'd20,
  parameter scope_rate_pkg::speed_t speed_step    = 16'sd1
) (
  input  logic                          CLK_50M,
  input  logic                          rst,
  input  scope_rate_pkg::speed_events_t events,
  output scope_rate_pkg::count_t        sample_count
);

  scope_rate_pkg::speed_t speed;

  // ============================================================
  // Speed register
  // ============================================================

  // Priority is hold_zero, then up, then down
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      speed <= '0;
    else if (events.hold_zero)
      speed <= '0;
    else if (events.up)
      speed <= speed + speed_step;
    else if (events.down)
      speed <= speed - speed_step;
  end

  // Divider setting, wraps modulo 2^16
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      sample_count <= default_count;
    else
      sample_count <= default_count + scope_rate_pkg::count_t'(speed);
  end

endmodule

//--- rtl/sample_clk_div.sv
`timescale 1ns/1ns

module sample_clk_div (
  input  logic                   CLK_50M,
  input  logic                   rst,
  input  scope_rate_pkg::count_t sample_count,
  output logic                   scope_sample_clk
);

  scope_rate_pkg::count_t div_cnt;
  logic                   terminal;

  // Also catches a count that dropped below the running counter
  assign terminal = (div_cnt >= sample_count);

  // Half period is sample_count+1 cycles
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      div_cnt          <= '0;
      scope_sample_clk <= 1'b0;
    end
    else if (terminal)
    begin
      div_cnt          <= '0;
      scope_sample_clk <= ~scope_sample_clk;
    end
    else
    begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

endmodule

//--- rtl/hex_display.sv
`timescale 1ns/1ns

module hex_display #(
  parameter int unsigned refresh_cycles = 4
) (
  input  logic                     CLK_50M,
  input  logic                     rst,
  input  scope_rate_pkg::count_t   sample_count,
  output scope_rate_pkg::hex_bus_t hex
);

  localparam int ref_w = (refresh_cycles > 1) ? $clog2(refresh_cycles) : 1;

  logic [ref_w-1:0] ref_cnt;
  logic             refresh;
  logic [23:0]      shown;

  // Active-low hex digit patterns
  function automatic scope_rate_pkg::seg_t seg_decode(input scope_rate_pkg::nibble_t nib);
    scope_rate_pkg::seg_t seg;
    case (nib)
      4'h0: seg = 7'b1000000;
      4'h1: seg = 7'b1111001;
      4'h2: seg = 7'b0100100;
      4'h3: seg = 7'b0110000;
      4'h4: seg = 7'b0011001;
      4'h5: seg = 7'b0010010;
      4'h6: seg = 7'b0000010;
      4'h7: seg = 7'b1111000;
      4'h8: seg = 7'b0000000;
      4'h9: seg = 7'b0010000;
      4'hA: seg = 7'b0001000;
      4'hB: seg = 7'b0000011;
      4'hC: seg = 7'b1000110;
      4'hD: seg = 7'b0100001;
      4'hE: seg = 7'b0000110;
      default: seg = 7'b0001110;
    endcase
    return seg;
  endfunction

  // ============================================================
  // Refresh latch
  // ============================================================

  assign refresh = (ref_cnt == ref_w'(refresh_cycles - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      ref_cnt <= '0;
      shown   <= '0;
    end
    else
    begin
      ref_cnt <= refresh ? '0 : ref_cnt + 1'b1;
      if (refresh)
        shown <= {8'h00, sample_count};
    end
  end

  // Upper two digits always read 0
  assign hex.digit0 = seg_decode(shown[3:0]);
  assign hex.digit1 = seg_decode(shown[7:4]);
  assign hex.digit2 = seg_decode(shown[11:8]);
  assign hex.digit3 = seg_decode(shown[15:12]);
  assign hex.digit4 = seg_decode(shown[19:16]);
  assign hex.digit5 = seg_decode(shown[23:20]);

endmodule

//--- rtl/scope_rate_top.sv
`timescale 1ns/1ns

module scope_rate_top #(
  parameter int unsigned            tick_cycles    = scope_rate_pkg::DEF_TICK_CYCLES,
  parameter int unsigned            repeat_ticks   = scope_rate_pkg::DEF_REPEAT_TICKS,
  parameter int unsigned            refresh_cycles = scope_rate_pkg::DEF_REFRESH_CYCLES,
  parameter scope_rate_pkg::count_t default_count  = scope_rate_pkg::DEF_DEFAULT_COUNT,
  parameter scope_rate_pkg::speed_t speed_step     = scope_rate_pkg::DEF_SPEED_STEP
) (
  input  logic                   CLK_50M,
  input  logic                   rst,
  input  logic [3:0]             key,
  output scope_rate_pkg::seg_t   hex0,
  output scope_rate_pkg::seg_t   hex1,
  output scope_rate_pkg::seg_t   hex2,
  output scope_rate_pkg::seg_t   hex3,
  output scope_rate_pkg::seg_t   hex4,
  output scope_rate_pkg::seg_t   hex5,
  output scope_rate_pkg::count_t sample_count,
  output logic                   scope_sample_clk
);

  scope_rate_pkg::speed_events_t events;
  scope_rate_pkg::hex_bus_t      hex;

  // ============================================================
  // Speed control path
  // ============================================================

  // key[3] has no function here
  key_repeat_gate #(
    .tick_cycles  (tick_cycles),
    .repeat_ticks (repeat_ticks)
  ) u_key_repeat_gate (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .key     (key[2:0]),
    .events  (events)
  );

  speed_config #(
    .default_count (default_count),
    .speed_step    (speed_step)
  ) u_speed_config (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .events       (events),
    .sample_count (sample_count)
  );

  sample_clk_div u_sample_clk_div (
    .CLK_50M          (CLK_50M),
    .rst              (rst),
    .sample_count     (sample_count),
    .scope_sample_clk (scope_sample_clk)
  );

  // ============================================================
  // Seven-segment display
  // ============================================================

  hex_display #(
    .refresh_cycles (refresh_cycles)
  ) u_hex_display (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .sample_count (sample_count),
    .hex          (hex)
  );

  assign hex0 = hex.digit0;
  assign hex1 = hex.digit1;
  assign hex2 = hex.digit2;
  assign hex3 = hex.digit3;
  assign hex4 = hex.digit4;
  assign hex5 = hex.digit5;

endmodule

//--- verif/scope_rate_tb.sv
`timescale 1ns/1ns

module scope_rate_tb;

  localparam scope_rate_pkg::count_t DEFAULT_COUNT = 16'd20;
  localparam int STEP = 3;

  logic                   CLK_50M;
  logic                   rst;
  logic [3:0]             key;
  scope_rate_pkg::seg_t   hex0;
  scope_rate_pkg::seg_t   hex1;
  scope_rate_pkg::seg_t   hex2;
  scope_rate_pkg::seg_t   hex3;
  scope_rate_pkg::seg_t   hex4;
  scope_rate_pkg::seg_t   hex5;
  scope_rate_pkg::count_t sample_count;
  logic                   scope_sample_clk;

  scope_rate_pkg::seg_t   seg_table [16];
  int unsigned            rng_state = 76;
  int                     errors = 0;
  int                     tests_run = 0;
  int                     tests_failed = 0;
  int                     test_errors = 0;
  int                     exp_delta = STEP;
  bit                     check_step = 1'b0;
  int                     changes = 0;
  int                     zero_low_cnt = 0;
  scope_rate_pkg::count_t prev_count = '0;
  scope_rate_pkg::count_t exp_count = DEFAULT_COUNT;

  scope_rate_top #(
    .tick_cycles    (4),
    .repeat_ticks   (5),
    .refresh_cycles (60),
    .default_count  (DEFAULT_COUNT),
    .speed_step     (scope_rate_pkg::speed_t'(STEP))
  ) u_scope_rate_top (
    .CLK_50M          (CLK_50M),
    .rst              (rst),
    .key              (key),
    .hex0             (hex0),
    .hex1             (hex1),
    .hex2             (hex2),
    .hex3             (hex3),
    .hex4             (hex4),
    .hex5             (hex5),
    .sample_count     (sample_count),
    .scope_sample_clk (scope_sample_clk)
  );

  initial CLK_50M = 1'b0;
  always #10 CLK_50M = ~CLK_50M;

  // ============================================================
  // Helpers
  // ============================================================

  function automatic int unsigned next_random();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return (rng_state >> 16) & 32'h7FFF;
  endfunction

  task automatic report_value(input string msg);
    errors++;
    $display("FAILED at time %0t: %s", $time, msg);
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timed out at time %0t while waiting for %s", $time, what);
    $display("Errors found");
    $finish;
  endtask

  task automatic close_test(input int num, input string name);
    tests_run++;
    if (errors != test_errors)
    begin
      tests_failed++;
      $display("test %0d %s: fail", num, name);
    end
    else
      $display("test %0d %s: pass", num, name);
    test_errors = errors;
  endtask

  // Pressed keys given as ones and driven active low
  task automatic hold_keys(input logic [3:0] pressed, input int cycles);
    key = ~pressed;
    repeat (cycles) @(negedge CLK_50M);
  endtask

  // Sync delay plus a possible last pulse
  task automatic release_and_settle();
    key = 4'hF;
    repeat (8) @(negedge CLK_50M);
  endtask

  task automatic wait_count(input scope_rate_pkg::count_t target, input int limit,
                            output int cycles);
    cycles = 0;
    while (sample_count != target && cycles <= limit)
    begin
      @(negedge CLK_50M);
      cycles++;
    end
    if (sample_count != target)
      abort_on_timeout($sformatf("sample_count to reach %0d", target));
  endtask

  task automatic wait_toggle(input int limit, output int cycles);
    logic start_level;
    start_level = scope_sample_clk;
    cycles = 0;
    while (scope_sample_clk == start_level && cycles <= limit)
    begin
      @(negedge CLK_50M);
      cycles++;
    end
    if (scope_sample_clk == start_level)
      abort_on_timeout("a toggle of scope_sample_clk");
  endtask

  task automatic check_digit(input int idx, input scope_rate_pkg::seg_t actual,
                             input logic [23:0] value);
    scope_rate_pkg::seg_t expected;
    expected = seg_table[value[idx*4 +: 4]];
    digit_check: assert (actual == expected)
      else report_value($sformatf("hex%0d is %b, expected %b", idx, actual, expected));
  endtask

  // ============================================================
  // Monitors
  // ============================================================

  // Every change of the count must be one step in the expected direction
  always @(negedge CLK_50M)
  begin
    if (!rst && check_step && sample_count != prev_count)
    begin
      step_check: assert (scope_rate_pkg::count_t'(sample_count - prev_count)
                          == scope_rate_pkg::count_t'(exp_delta))
        else report_value($sformatf("count went %0d to %0d, expected step %0d",
                                    prev_count, sample_count, exp_delta));
      exp_count = exp_count + scope_rate_pkg::count_t'(exp_delta);
      changes++;
    end
    prev_count = sample_count;
  end

  // Consecutive cycles with the speed-reset key low
  always @(posedge CLK_50M)
  begin
    if (rst || key[2])
      zero_low_cnt <= 0;
    else if (zero_low_cnt < 1000)
      zero_low_cnt <= zero_low_cnt + 1;
  end

  zero_hold_check: assert property (@(posedge CLK_50M) disable iff (rst)
                                    (zero_low_cnt >= 4) |-> (sample_count == DEFAULT_COUNT))
    else report_value($sformatf("count %0d while speed-reset held", sample_count));

  // ============================================================
  // Stimulus
  // ============================================================

  initial
  begin
    int first;
    int cycles;
    logic [23:0] shown;
    seg_table = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                  7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
    rst = 1'b1;
    key = 4'hF;
    repeat (16) @(negedge CLK_50M);
    rst = 1'b0;
    @(negedge CLK_50M);

    reset_count: assert (sample_count == DEFAULT_COUNT)
      else report_value($sformatf("count %0d after reset", sample_count));
    reset_clk: assert (scope_sample_clk == 1'b0)
      else report_value("sample clock high after reset");
    for (int i = 0; i < 6; i++)
      check_digit(i, scope_rate_pkg::seg_t'({hex5, hex4, hex3, hex2, hex1, hex0} >> (7 * i)),
                  24'h0);
    close_test(1, "reset values");

    check_step = 1'b1;
    first = changes;
    hold_keys(4'b0001, 25 + next_random() % 40);
    release_and_settle();
    up_seen: assert (changes > first)
      else report_value("no speed-up step seen");
    up_total: assert (sample_count == DEFAULT_COUNT
                      + scope_rate_pkg::count_t'(STEP * (changes - first)))
      else report_value($sformatf("count %0d is not 20 plus steps of 3", sample_count));
    close_test(2, "speed-up repeat");

    exp_delta = -STEP;
    first = changes;
    hold_keys(4'b0010, 25 + next_random() % 40);
    release_and_settle();
    down_seen: assert (changes > first)
      else report_value("no speed-down step seen");
    // Up wins when both are held
    exp_delta = STEP;
    first = changes;
    hold_keys(4'b0011, 25 + next_random() % 40);
    release_and_settle();
    both_seen: assert (changes > first && sample_count == exp_count)
      else report_value($sformatf("count %0d, model %0d", sample_count, exp_count));
    close_test(3, "speed-down and both keys");

    if (sample_count == DEFAULT_COUNT)
    begin
      key = 4'b1110;
      wait_count(DEFAULT_COUNT + 16'd3, 60, cycles);
      release_and_settle();
    end
    check_step = 1'b0;
    key = 4'b1010;
    wait_count(DEFAULT_COUNT, 20, cycles);
    reset_latency: assert (cycles <= 4)
      else report_value($sformatf("speed-reset took %0d cycles", cycles));
    repeat (60) @(negedge CLK_50M);
    exp_count = DEFAULT_COUNT;
    release_and_settle();
    after_zero: assert (sample_count == DEFAULT_COUNT)
      else report_value($sformatf("count %0d after speed-reset release", sample_count));
    check_step = 1'b1;
    close_test(4, "speed-reset");

    hold_keys(4'b0001, 25 + next_random() % 40);
    release_and_settle();
    repeat (70) @(negedge CLK_50M);
    shown = {8'h00, exp_count};
    model_match: assert (sample_count == exp_count)
      else report_value($sformatf("count %0d, model %0d", sample_count, exp_count));
    check_digit(0, hex0, shown);
    check_digit(1, hex1, shown);
    check_digit(2, hex2, shown);
    check_digit(3, hex3, shown);
    check_digit(4, hex4, shown);
    check_digit(5, hex5, shown);
    close_test(5, "hex display");

    // Skip the partial half period first
    wait_toggle(2 * int'(exp_count) + 20, cycles);
    wait_toggle(2 * int'(exp_count) + 20, cycles);
    for (int i = 0; i < 3; i++)
    begin
      wait_toggle(2 * int'(exp_count) + 20, cycles);
      half_period: assert (cycles == int'(exp_count) + 1)
        else report_value($sformatf("half period %0d, count %0d", cycles, exp_count));
    end
    close_test(6, "sample clock divider");

    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

//--- scope_rate.f
rtl/scope_rate_pkg.sv
rtl/key_repeat_gate.sv
rtl/speed_config.sv
rtl/sample_clk_div.sv
rtl/hex_display.sv
rtl/scope_rate_top.sv
verif/scope_rate_tb.sv

//--- Bender.yml
package:
  name: scope_rate

sources:
  - files:
      - rtl/scope_rate_pkg.sv
      - rtl/key_repeat_gate.sv
      - rtl/speed_config.sv
      - rtl/sample_clk_div.sv
      - rtl/hex_display.sv
      - rtl/scope_rate_top.sv
  - target: test
    files:
      - verif/scope_rate_tb.sv
